/* hw/oramPkg.sv */
//--------------------------------------------------------------------
// Shared geometry, bucket word layout and enums for the ORAM backend
// Modules import this package inside their bodies
//--------------------------------------------------------------------
package oramPkg;

	//--------------------------------------------------------------------
	// Tree geometry
	//--------------------------------------------------------------------

	// Levels below the root, so the tree has oramLevels + 1 levels
	localparam int oramLevels = 3;
	localparam int levelWidth = $clog2(oramLevels + 1);
	localparam int leafWidth = 3;
	localparam int addrWidth = 3;
	localparam int dataWidth = 16;
	// Heap order, root is bucket 0
	localparam int bucketCount = 15;
	localparam int dramAddrWidth = 4;

	// Bucket word is {valid, addr, leaf, data}, MSB first
	localparam int dramWordWidth = 1 + addrWidth + leafWidth + dataWidth;

	// Enough for every logical block at once
	localparam int stashDepth = 8;

	//--------------------------------------------------------------------
	// Commands and states
	//--------------------------------------------------------------------

	typedef enum logic {
		oramRead,
		oramWrite
	} oramCommand;

	typedef enum logic {
		dramRead,
		dramWrite
	} dramCommand;

	typedef enum logic [2:0] {
		stInitialize,
		stIdle,
		stReadPath,
		stFinish,
		stWritePath
	} controlState;

endpackage

/* hw/backendControl.sv */
//--------------------------------------------------------------------
// Backend control FSM, frontend command latch and DRAM command mux
// Initializer owns the DRAM channel until init is done
//--------------------------------------------------------------------
module backendControl (
	input  logic                                Clock,
	input  logic                                rst,
	input  oramPkg::oramCommand                 command,
	input  logic [oramPkg::addrWidth-1:0]       paddr,
	input  logic [oramPkg::leafWidth-1:0]       currentLeaf,
	input  logic [oramPkg::leafWidth-1:0]       remappedLeaf,
	input  logic [oramPkg::dataWidth-1:0]       storeData,
	input  logic                                commandValid,
	output logic                                commandReady,
	input  logic                                initCmdValid,
	input  logic [oramPkg::dramAddrWidth-1:0]   initAddress,
	input  logic                                initDone,
	output logic                                initCmdReady,
	input  logic [oramPkg::dramAddrWidth-1:0]   pathAddress,
	input  logic                                pathValid,
	input  logic                                pathDone,
	output logic                                pathStart,
	output logic                                pathWriteBack,
	output logic                                pathReady,
	output logic [oramPkg::addrWidth-1:0]       accessAddr,
	output logic [oramPkg::leafWidth-1:0]       accessLeaf,
	output logic [oramPkg::leafWidth-1:0]       accessNewLeaf,
	output logic                                accessIsWrite,
	output logic [oramPkg::dataWidth-1:0]       accessData,
	output logic                                readEnable,
	output logic                                finishAccess,
	output logic                                evictTake,
	input  logic [oramPkg::dramWordWidth-1:0]   evictWord,
	output logic                                loadValid,
	output logic [oramPkg::dramAddrWidth-1:0]   dramAddress,
	output oramPkg::dramCommand                 dramCmd,
	output logic [oramPkg::dramWordWidth-1:0]   dramWriteData,
	output logic                                dramCmdValid,
	input  logic                                dramCmdReady,
	input  logic                                dramReadValid
);
	import oramPkg::*;

	controlState           state;
	controlState           nextState;
	logic                  initializing;
	logic                  accept;
	logic [levelWidth-1:0] readCount;

	assign initializing = state == stInitialize;
	assign commandReady = state == stIdle;
	assign accept = commandValid && commandReady;

	//--------------------------------------------------------------------
	// FSM
	//--------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (rst)
			state <= stInitialize;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			stInitialize:
				if (initDone)
					nextState = stIdle;
			stIdle:
				if (accept)
					nextState = stReadPath;
			// Leave on the last returned word, not the last read command
			stReadPath:
				if (dramReadValid && readCount == levelWidth'(oramLevels))
					nextState = stFinish;
			stFinish:
				nextState = stWritePath;
			stWritePath:
				if (pathDone)
					nextState = stIdle;
			default:
				nextState = stInitialize;
		endcase
	end

	// Returned read words of the current path
	always_ff @(posedge Clock) begin
		if (rst || accept)
			readCount <= '0;
		else if (readEnable)
			readCount <= readCount + 1'b1;
	end

	// Access latch, held for the whole access
	always_ff @(posedge Clock) begin
		if (accept) begin
			accessAddr <= paddr;
			accessLeaf <= currentLeaf;
			accessNewLeaf <= remappedLeaf;
			accessIsWrite <= command == oramWrite;
			accessData <= storeData;
		end
	end

	//--------------------------------------------------------------------
	// Path and stash strobes
	//--------------------------------------------------------------------

	// Read path starts on acceptance, write-back from stFinish
	assign pathStart = accept || state == stFinish;
	assign pathWriteBack = state == stFinish;
	assign readEnable = dramReadValid && state == stReadPath;
	assign finishAccess = state == stFinish;
	assign loadValid = state == stFinish;
	assign evictTake = state == stWritePath && pathValid && dramCmdReady;

	//--------------------------------------------------------------------
	// DRAM command mux
	//--------------------------------------------------------------------

	assign initCmdReady = dramCmdReady && initializing;
	assign pathReady = dramCmdReady && !initializing;

	always_comb begin
		if (initializing) begin
			dramAddress = initAddress;
			dramCmd = dramWrite;
			// Empty bucket word
			dramWriteData = '0;
			dramCmdValid = initCmdValid;
		end else begin
			dramAddress = pathAddress;
			dramCmd = (state == stWritePath) ? dramWrite : dramRead;
			dramWriteData = evictWord;
			dramCmdValid = pathValid;
		end
	end

endmodule

/* hw/dramInitializer.sv */
//--------------------------------------------------------------------
// Writes an empty word to every bucket once after reset
//--------------------------------------------------------------------
module dramInitializer (
	input  logic                                Clock,
	input  logic                                rst,
	input  logic                                initCmdReady,
	output logic                                initCmdValid,
	output logic [oramPkg::dramAddrWidth-1:0]   initAddress,
	output logic                                initDone
);
	import oramPkg::*;

	logic [dramAddrWidth-1:0] bucket;
	logic                     initFinished;
	logic                     transfer;
	logic                     lastTransfer;

	assign transfer = initCmdValid && initCmdReady;
	assign lastTransfer = transfer && bucket == dramAddrWidth'(bucketCount - 1);
	assign initAddress = bucket;
	// Also high in the last transfer cycle so control leaves init at once
	assign initDone = initFinished || lastTransfer;

	always_ff @(posedge Clock) begin
		if (rst) begin
			bucket <= '0;
			initCmdValid <= 1'b0;
			initFinished <= 1'b0;
		end else if (lastTransfer) begin
			initCmdValid <= 1'b0;
			initFinished <= 1'b1;
		end else begin
			// Valid rises one cycle after reset
			if (!initFinished)
				initCmdValid <= 1'b1;
			if (transfer)
				bucket <= bucket + 1'b1;
		end
	end

endmodule

/* hw/pathAddrGen.sv */
//--------------------------------------------------------------------
// Bucket addresses of one path, root to leaf or leaf to root
// Started by a pathStart pulse, steps on each ready transfer
//--------------------------------------------------------------------
module pathAddrGen (
	input  logic                                Clock,
	input  logic                                rst,
	input  logic                                pathStart,
	input  logic                                pathWriteBack,
	input  logic [oramPkg::leafWidth-1:0]       currentLeaf,
	input  logic                                pathReady,
	output logic [oramPkg::dramAddrWidth-1:0]   pathAddress,
	output logic [oramPkg::levelWidth-1:0]      pathLevel,
	output logic                                pathValid,
	output logic                                pathDone
);
	import oramPkg::*;

	logic                     active;
	logic                     writeBack;
	logic [levelWidth-1:0]    level;
	logic                     lastLevel;
	logic [dramAddrWidth-1:0] levelBase;
	logic [dramAddrWidth-1:0] levelOffset;

	// Leaf end for reads, root end for write-back
	assign lastLevel = writeBack ? level == '0 : level == levelWidth'(oramLevels);
	assign pathDone = active && pathReady && lastLevel;
	assign pathValid = active;
	assign pathLevel = level;

	// Heap index is 2^l - 1 plus the top l bits of the leaf
	assign levelBase = dramAddrWidth'((1 << level) - 1);
	assign levelOffset = dramAddrWidth'(currentLeaf >> (oramLevels - level));
	assign pathAddress = levelBase + levelOffset;

	always_ff @(posedge Clock) begin
		if (rst) begin
			active <= 1'b0;
			writeBack <= 1'b0;
			level <= '0;
		end else if (pathStart) begin
			active <= 1'b1;
			writeBack <= pathWriteBack;
			level <= pathWriteBack ? levelWidth'(oramLevels) : '0;
		end else if (active && pathReady) begin
			if (lastLevel)
				active <= 1'b0;
			else if (writeBack)
				level <= level - 1'b1;
			else
				level <= level + 1'b1;
		end
	end

endmodule

/* hw/blockStash.sv */
//--------------------------------------------------------------------
// Stash of real blocks pulled off the path
// Updates the target block and offers blocks for write-back eviction
//--------------------------------------------------------------------
module blockStash (
	input  logic                                Clock,
	input  logic                                rst,
	input  logic [oramPkg::addrWidth-1:0]       accessAddr,
	input  logic [oramPkg::leafWidth-1:0]       accessLeaf,
	input  logic [oramPkg::leafWidth-1:0]       accessNewLeaf,
	input  logic                                accessIsWrite,
	input  logic [oramPkg::dataWidth-1:0]       accessData,
	input  logic                                readEnable,
	input  logic [oramPkg::dramWordWidth-1:0]   dramReadData,
	input  logic                                finishAccess,
	input  logic [oramPkg::levelWidth-1:0]      pathLevel,
	input  logic                                evictTake,
	output logic [oramPkg::dramWordWidth-1:0]   evictWord,
	output logic [oramPkg::dataWidth-1:0]       loadData
);
	import oramPkg::*;

	logic [stashDepth-1:0] entryValid;
	logic [addrWidth-1:0]  entryAddr [stashDepth];
	logic [leafWidth-1:0]  entryLeaf [stashDepth];
	logic [dataWidth-1:0]  entryData [stashDepth];

	// Fields of the incoming bucket word
	logic                  wordValid;
	logic [addrWidth-1:0]  wordAddr;
	logic [leafWidth-1:0]  wordLeaf;
	logic [dataWidth-1:0]  wordData;

	int                    freeIndex;
	int                    targetIndex;
	logic                  targetHit;
	int                    evictIndex;
	logic                  evictHit;

	assign {wordValid, wordAddr, wordLeaf, wordData} = dramReadData;

	//--------------------------------------------------------------------
	// Lookups, lowest index wins
	//--------------------------------------------------------------------

	always_comb begin
		freeIndex = 0;
		targetIndex = 0;
		targetHit = 1'b0;
		evictIndex = 0;
		evictHit = 1'b0;
		for (int i = stashDepth - 1; i >= 0; i--) begin
			if (!entryValid[i])
				freeIndex = i;
			if (entryValid[i] && entryAddr[i] == accessAddr) begin
				targetIndex = i;
				targetHit = 1'b1;
			end
			// Leaf must share the top pathLevel bits with the path leaf
			if (entryValid[i] && (entryLeaf[i] >> (oramLevels - pathLevel)) ==
					(accessLeaf >> (oramLevels - pathLevel))) begin
				evictIndex = i;
				evictHit = 1'b1;
			end
		end
	end

	// Never written blocks read as zero
	assign loadData = targetHit ? entryData[targetIndex] : '0;

	// Empty word when nothing fits this level
	assign evictWord = evictHit ?
		{1'b1, entryAddr[evictIndex], entryLeaf[evictIndex], entryData[evictIndex]} : '0;

	//--------------------------------------------------------------------
	// Entry updates
	//--------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (rst) begin
			entryValid <= '0;
		end else begin
			if (readEnable && wordValid)
				entryValid[freeIndex] <= 1'b1;
			// Target created on first touch
			if (finishAccess && !targetHit)
				entryValid[freeIndex] <= 1'b1;
			if (evictTake && evictHit)
				entryValid[evictIndex] <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (readEnable && wordValid) begin
			entryAddr[freeIndex] <= wordAddr;
			entryLeaf[freeIndex] <= wordLeaf;
			entryData[freeIndex] <= wordData;
		end
		if (finishAccess) begin
			if (targetHit) begin
				entryLeaf[targetIndex] <= accessNewLeaf;
				if (accessIsWrite)
					entryData[targetIndex] <= accessData;
			end else begin
				entryAddr[freeIndex] <= accessAddr;
				entryLeaf[freeIndex] <= accessNewLeaf;
				entryData[freeIndex] <= accessIsWrite ? accessData : '0;
			end
		end
	end

endmodule

/* hw/oramBackend.sv */
//--------------------------------------------------------------------
// Path ORAM backend top level, one Z=1 bucket per DRAM word
// Frontend supplies the leaf and remapped leaf for every access
//--------------------------------------------------------------------
module oramBackend (
	input  logic                                Clock,
	input  logic                                rst,
	// Frontend command
	input  oramPkg::oramCommand                 command,
	input  logic [oramPkg::addrWidth-1:0]       paddr,
	input  logic [oramPkg::leafWidth-1:0]       currentLeaf,
	input  logic [oramPkg::leafWidth-1:0]       remappedLeaf,
	input  logic [oramPkg::dataWidth-1:0]       storeData,
	input  logic                                commandValid,
	output logic                                commandReady,
	// Load return
	output logic [oramPkg::dataWidth-1:0]       loadData,
	output logic                                loadValid,
	// DRAM command and read return
	output logic [oramPkg::dramAddrWidth-1:0]   dramAddress,
	output oramPkg::dramCommand                 dramCmd,
	output logic [oramPkg::dramWordWidth-1:0]   dramWriteData,
	output logic                                dramCmdValid,
	input  logic                                dramCmdReady,
	input  logic [oramPkg::dramWordWidth-1:0]   dramReadData,
	input  logic                                dramReadValid
);
	import oramPkg::*;

	// Initializer channel
	logic                     initCmdValid;
	logic                     initCmdReady;
	logic [dramAddrWidth-1:0] initAddress;
	logic                     initDone;

	// Path generator channel
	logic                     pathStart;
	logic                     pathWriteBack;
	logic                     pathReady;
	logic [dramAddrWidth-1:0] pathAddress;
	logic [levelWidth-1:0]    pathLevel;
	logic                     pathValid;
	logic                     pathDone;

	// Latched access and stash control
	logic [addrWidth-1:0]     accessAddr;
	logic [leafWidth-1:0]     accessLeaf;
	logic [leafWidth-1:0]     accessNewLeaf;
	logic                     accessIsWrite;
	logic [dataWidth-1:0]     accessData;
	logic                     readEnable;
	logic                     finishAccess;
	logic                     evictTake;
	logic [dramWordWidth-1:0] evictWord;

	backendControl control (
		.Clock(Clock), .rst(rst),
		.command(command), .paddr(paddr), .currentLeaf(currentLeaf),
		.remappedLeaf(remappedLeaf), .storeData(storeData),
		.commandValid(commandValid), .commandReady(commandReady),
		.initCmdValid(initCmdValid), .initAddress(initAddress),
		.initDone(initDone), .initCmdReady(initCmdReady),
		.pathAddress(pathAddress), .pathValid(pathValid), .pathDone(pathDone),
		.pathStart(pathStart), .pathWriteBack(pathWriteBack), .pathReady(pathReady),
		.accessAddr(accessAddr), .accessLeaf(accessLeaf),
		.accessNewLeaf(accessNewLeaf), .accessIsWrite(accessIsWrite),
		.accessData(accessData), .readEnable(readEnable),
		.finishAccess(finishAccess), .evictTake(evictTake), .evictWord(evictWord),
		.loadValid(loadValid),
		.dramAddress(dramAddress), .dramCmd(dramCmd), .dramWriteData(dramWriteData),
		.dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramReadValid(dramReadValid)
	);

	dramInitializer initializer (
		.Clock(Clock), .rst(rst),
		.initCmdReady(initCmdReady), .initCmdValid(initCmdValid),
		.initAddress(initAddress), .initDone(initDone)
	);

	pathAddrGen addrGen (
		.Clock(Clock), .rst(rst),
		.pathStart(pathStart), .pathWriteBack(pathWriteBack),
		.currentLeaf(accessLeaf), .pathReady(pathReady),
		.pathAddress(pathAddress), .pathLevel(pathLevel),
		.pathValid(pathValid), .pathDone(pathDone)
	);

	blockStash stash (
		.Clock(Clock), .rst(rst),
		.accessAddr(accessAddr), .accessLeaf(accessLeaf),
		.accessNewLeaf(accessNewLeaf), .accessIsWrite(accessIsWrite),
		.accessData(accessData), .readEnable(readEnable),
		.dramReadData(dramReadData), .finishAccess(finishAccess),
		.pathLevel(pathLevel), .evictTake(evictTake),
		.evictWord(evictWord), .loadData(loadData)
	);

endmodule

/* verif/oramBackend_checker.sv */
//--------------------------------------------------------------------
// Protocol assertions on the frontend, load and DRAM command ports
// Bound into every oramBackend instance
//--------------------------------------------------------------------
module oramBackend_checker (
	input  logic                                Clock,
	input  logic                                rst,
	input  logic                                commandReady,
	input  logic                                dramCmdValid,
	input  logic                                dramCmdReady,
	input  logic [oramPkg::dramAddrWidth-1:0]   dramAddress,
	input  oramPkg::dramCommand                 dramCmd,
	input  logic                                loadValid
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertions so far
	int failCount = 0;

	// No new frontend command while the DRAM channel is busy
	readyIdle: assert property (@(posedge Clock) disable iff (rst)
		dramCmdValid |-> !commandReady)
		else begin
			$error("commandReady is high while a DRAM command is pending");
			failCount++;
		end

	// Stalled command holds until it transfers
	cmdHold: assert property (@(posedge Clock) disable iff (rst)
		dramCmdValid && !dramCmdReady |=>
			dramCmdValid && $stable(dramAddress) && $stable(dramCmd))
		else begin
			$error("DRAM command changed or dropped while stalled");
			failCount++;
		end

	loadPulse: assert property (@(posedge Clock) disable iff (rst)
		loadValid |=> !loadValid)
		else begin
			$error("loadValid lasted more than one cycle");
			failCount++;
		end

endmodule

bind oramBackend oramBackend_checker protocolChecker (.*);

/* verif/oramBackend_tb.sv */
//--------------------------------------------------------------------
// Testbench for the ORAM backend with a DRAM model and a block model
// Random accesses and DRAM stalls come from a fixed-seed LFSR
//--------------------------------------------------------------------
module oramBackend_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import oramPkg::*;

	logic                     Clock;
	logic                     rst;
	oramCommand               command;
	logic [addrWidth-1:0]     paddr;
	logic [leafWidth-1:0]     currentLeaf;
	logic [leafWidth-1:0]     remappedLeaf;
	logic [dataWidth-1:0]     storeData;
	logic                     commandValid;
	logic                     commandReady;
	logic [dataWidth-1:0]     loadData;
	logic                     loadValid;
	logic [dramAddrWidth-1:0] dramAddress;
	dramCommand               dramCmd;
	logic [dramWordWidth-1:0] dramWriteData;
	logic                     dramCmdValid;
	logic                     dramCmdReady;
	logic [dramWordWidth-1:0] dramReadData;
	logic                     dramReadValid;

	// Reference state
	logic [dramWordWidth-1:0] mem [bucketCount];
	logic [dataWidth-1:0]     dataModel [8];
	logic [leafWidth-1:0]     posMap [8];
	// Observed DRAM commands of the current phase
	logic [dramAddrWidth-1:0] seenAddr [$];
	logic                     seenWrite [$];
	logic [dramWordWidth-1:0] seenData [$];
	int                       loadCount;
	// Pending read returns, in order
	logic [dramWordWidth-1:0] readDataQ [$];
	int                       readDueQ [$];
	int                       lastDue;
	int                       cycle;

	logic [31:0]              stimLfsr;
	logic [31:0]              dramLfsr;
	logic                     stallEnable;
	logic                     initPhase;
	logic                     timedOut;
	int                       checkCount;
	int                       errorCount;

	// Access in flight, used at loadValid
	logic                     curWrite;
	logic [addrWidth-1:0]     curAddr;
	logic [leafWidth-1:0]     curNewLeaf;
	logic [dataWidth-1:0]     curData;

	oramBackend i_dut (
		.Clock(Clock), .rst(rst),
		.command(command), .paddr(paddr), .currentLeaf(currentLeaf),
		.remappedLeaf(remappedLeaf), .storeData(storeData),
		.commandValid(commandValid), .commandReady(commandReady),
		.loadData(loadData), .loadValid(loadValid),
		.dramAddress(dramAddress), .dramCmd(dramCmd), .dramWriteData(dramWriteData),
		.dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramReadData(dramReadData), .dramReadValid(dramReadValid)
	);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	//--------------------------------------------------------------------
	// Helpers
	//--------------------------------------------------------------------

	// Galois LFSR, taps 32 31 29 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 32'hd000_0001;
		return next;
	endfunction

	// One LFSR step per bit taken
	task automatic drawBits(inout logic [31:0] state, input int count,
			output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			state = lfsrStep(state);
			value = {value[30:0], state[0]};
		end
	endtask

	// Walk down from the root, left child for a 0 leaf bit, MSB first
	function automatic int pathBucket(input int leaf, input int level);
		int bucket;
		bucket = 0;
		for (int l = 0; l < level; l++)
			bucket = 2 * bucket + 1 + ((leaf >> (oramLevels - 1 - l)) & 1);
		return bucket;
	endfunction

	function automatic int levelOf(input int bucket);
		int level;
		level = 0;
		for (int l = 0; l <= oramLevels; l++)
			if (bucket >= (1 << l) - 1)
				level = l;
		return level;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name,
				actual, expected);
		end
	endtask

	//--------------------------------------------------------------------
	// DRAM model and output monitor
	//--------------------------------------------------------------------

	always @(posedge Clock) begin : dramModel
		logic [addrWidth-1:0] wAddr;
		logic [leafWidth-1:0] wLeaf;
		logic [31:0]          bits;
		int                   due;
		cycle++;
		// Read returns, one word per cycle once due
		if (readDataQ.size() > 0 && readDueQ[0] <= cycle) begin
			dramReadValid <= 1'b1;
			dramReadData <= readDataQ.pop_front();
			void'(readDueQ.pop_front());
		end else begin
			dramReadValid <= 1'b0;
		end
		if (!rst && dramCmdValid && dramCmdReady) begin
			seenAddr.push_back(dramAddress);
			seenWrite.push_back(dramCmd == dramWrite);
			seenData.push_back(dramWriteData);
			if (dramCmd == dramWrite) begin
				mem[dramAddress] = dramWriteData;
				// Real block must sit on its own leaf's path
				if (!initPhase && dramWriteData[dramWordWidth-1]) begin
					wAddr = dramWriteData[dataWidth+leafWidth +: addrWidth];
					wLeaf = dramWriteData[dataWidth +: leafWidth];
					checkValue("bucket of written block", dramAddress,
						pathBucket(wLeaf, levelOf(dramAddress)));
					checkValue("leaf of written block", wLeaf, posMap[wAddr]);
					checkValue("data of written block", dramWriteData[dataWidth-1:0],
						dataModel[wAddr]);
				end
			end else begin
				bits = '0;
				if (stallEnable)
					drawBits(dramLfsr, 2, bits);
				due = cycle + 1 + int'(bits);
				// Keep returns in order
				if (due < lastDue)
					due = lastDue;
				lastDue = due;
				readDataQ.push_back(mem[dramAddress]);
				readDueQ.push_back(due);
			end
		end
		if (!rst && loadValid) begin
			loadCount++;
			checkValue("loadData", loadData, dataModel[curAddr]);
			if (curWrite)
				dataModel[curAddr] = curData;
			posMap[curAddr] = curNewLeaf;
		end
		// Stall about one cycle in four
		if (stallEnable) begin
			drawBits(dramLfsr, 2, bits);
			dramCmdReady <= bits != 0;
		end else begin
			dramCmdReady <= 1'b1;
		end
	end

	//--------------------------------------------------------------------
	// Stimulus
	//--------------------------------------------------------------------

	task automatic clearSeen();
		seenAddr.delete();
		seenWrite.delete();
		seenData.delete();
		loadCount = 0;
	endtask

	task automatic checkInit();
		int waited;
		waited = 0;
		while (!commandReady && waited < 200) begin
			@(posedge Clock);
			waited++;
		end
		if (!commandReady) begin
			$display("Initialization did not finish within 200 cycles");
			timedOut = 1'b1;
		end else begin
			checkValue("init write count", seenAddr.size(), bucketCount);
			for (int i = 0; i < seenAddr.size(); i++) begin
				checkValue("init address", seenAddr[i], i);
				checkValue("init command is write", seenWrite[i], 1);
				checkValue("init write data", seenData[i], 0);
			end
		end
		clearSeen();
		initPhase = 1'b0;
		$display("initialization: %0d errors", errorCount);
	endtask

	task automatic runAccess();
		logic [31:0]    bits;
		logic [leafWidth-1:0] leaf;
		int             waited;
		int             level;
		int             copies;
		drawBits(stimLfsr, 1, bits);
		curWrite = bits[0];
		drawBits(stimLfsr, addrWidth, bits);
		curAddr = bits[addrWidth-1:0];
		drawBits(stimLfsr, leafWidth, bits);
		curNewLeaf = bits[leafWidth-1:0];
		drawBits(stimLfsr, dataWidth, bits);
		curData = bits[dataWidth-1:0];
		leaf = posMap[curAddr];
		command <= curWrite ? oramWrite : oramRead;
		paddr <= curAddr;
		currentLeaf <= leaf;
		remappedLeaf <= curNewLeaf;
		storeData <= curData;
		commandValid <= 1'b1;
		// Handshake
		waited = 0;
		do begin
			@(posedge Clock);
			waited++;
		end while (!commandReady && waited < 50);
		commandValid <= 1'b0;
		if (!commandReady) begin
			$display("Access was not accepted within 50 cycles");
			timedOut = 1'b1;
		end else begin
			// End of access is commandReady back high
			waited = 0;
			do begin
				@(posedge Clock);
				waited++;
			end while (!commandReady && waited < 200);
			if (!commandReady) begin
				$display("Access did not complete within 200 cycles");
				timedOut = 1'b1;
			end else begin
				checkValue("path command count", seenAddr.size(), 2 * (oramLevels + 1));
				checkValue("loadValid pulse count", loadCount, 1);
				if (seenAddr.size() == 2 * (oramLevels + 1)) begin
					for (int i = 0; i < seenAddr.size(); i++) begin
						level = (i <= oramLevels) ? i : 2 * oramLevels + 1 - i;
						checkValue("path address", seenAddr[i], pathBucket(leaf, level));
						checkValue("path command is write", seenWrite[i], i > oramLevels);
					end
				end
				// A block lives in at most one bucket
				for (int p = 0; p < 8; p++) begin
					copies = 0;
					for (int b = 0; b < bucketCount; b++)
						if (mem[b][dramWordWidth-1] &&
								mem[b][dataWidth+leafWidth +: addrWidth] == p)
							copies++;
					checkValue("block stored at most once", copies <= 1, 1);
				end
			end
		end
		clearSeen();
	endtask

	task automatic runTest(input string name, input int count, input logic stalls);
		int startErrors;
		int done;
		startErrors = errorCount;
		stallEnable <= stalls;
		done = 0;
		while (done < count && !timedOut) begin
			runAccess();
			done++;
		end
		$display("%s: %0d accesses, %0d errors", name, done, errorCount - startErrors);
	endtask

	initial begin
		rst = 1'b1;
		command = oramRead;
		paddr = '0;
		currentLeaf = '0;
		remappedLeaf = '0;
		storeData = '0;
		commandValid = 1'b0;
		dramCmdReady = 1'b1;
		dramReadData = '0;
		dramReadValid = 1'b0;
		stimLfsr = 32'hc2d8;
		dramLfsr = 32'hc2d8;
		stallEnable = 1'b0;
		initPhase = 1'b1;
		timedOut = 1'b0;
		checkCount = 0;
		errorCount = 0;
		loadCount = 0;
		cycle = 0;
		lastDue = 0;
		for (int i = 0; i < 8; i++) begin
			dataModel[i] = '0;
			posMap[i] = leafWidth'(i);
		end
		// Stale contents, overwritten by init
		for (int i = 0; i < bucketCount; i++)
			mem[i] = dramWordWidth'(32'h5a5a5a ^ (i * 32'h9e37));
		repeat (2) @(posedge Clock);
		rst <= 1'b0;
		@(posedge Clock);
		checkInit();
		if (!timedOut)
			runTest("accesses without stalls", 40, 1'b0);
		if (!timedOut)
			runTest("accesses with stalls and read delays", 200, 1'b1);
		checkValue("assertion failures", i_dut.protocolChecker.failCount, 0);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && !timedOut)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* oramBackend.f */
hw/oramPkg.sv
hw/backendControl.sv
hw/dramInitializer.sv
hw/pathAddrGen.sv
hw/blockStash.sv
hw/oramBackend.sv
verif/oramBackend_checker.sv
verif/oramBackend_tb.sv
